//--- src/dcache_ram_pkg.sv
`default_nettype none

package dcache_ram_pkg;

  // ----------------------------------------------------------------------
  // macro geometry
  // ----------------------------------------------------------------------
  localparam int MACRO_WIDTH = 32;                    // data bits per macro
  localparam int MACRO_BYTES = MACRO_WIDTH / 8;       // byte lanes per macro

  // ----------------------------------------------------------------------
  // data array geometry
  // ----------------------------------------------------------------------
  localparam int DATA_WIDTH      = 64;                // cache word
  localparam int DATA_BYTES      = DATA_WIDTH / 8;    // one mask bit per byte
  localparam int DATA_BANKS      = 2;                 // address-decoded banks
  localparam int DATA_BANK_DEPTH = 512;               // words per bank
  localparam int DATA_ADDR_WIDTH = $clog2(DATA_BANKS * DATA_BANK_DEPTH); // msb picks bank

  // ----------------------------------------------------------------------
  // tag array geometry
  // ----------------------------------------------------------------------
  localparam int TAG_WAYS        = 2;                 // associativity
  localparam int TAG_WAY_WIDTH   = 21;                // tag bits per way
  localparam int TAG_DEPTH       = 64;                // sets
  localparam int TAG_MACRO_DEPTH = 256;               // macro is deeper than needed
  localparam int TAG_ADDR_WIDTH  = $clog2(TAG_DEPTH); // set index

  // one way's stored tag
  typedef logic [TAG_WAY_WIDTH-1:0] tag_way_t;

  // ----------------------------------------------------------------------
  // request bundles
  // ----------------------------------------------------------------------
  // data array access, read data comes back one cycle later
  typedef struct packed {
    logic                       en;     // access this cycle
    logic                       wmode;  // 1 write, 0 read
    logic [DATA_ADDR_WIDTH-1:0] addr;   // word address
    logic [DATA_BYTES-1:0]      wmask;  // byte enables on write
    logic [DATA_WIDTH-1:0]      wdata;  // write payload
  } dc_data_req_t;

  // tag array access, way 1 sits in the upper half of wdata
  typedef struct packed {
    logic                      en;      // access this cycle
    logic                      wmode;   // 1 write, 0 read
    logic [TAG_ADDR_WIDTH-1:0] addr;    // set index
    logic [TAG_WAYS-1:0]       wmask;   // one bit per way
    tag_way_t [TAG_WAYS-1:0]   wdata;   // per-way tags
  } dc_tag_req_t;

endpackage

`default_nettype wire

//--- src/sram_macro.sv
`default_nettype none

// Behavioural stand-in for the 32-bit single-port SRAM hard macro.
// One access per clock; reads return on the following edge and the
// output holds between reads.
module sram_macro
  import dcache_ram_pkg::*;
#(
  parameter int DEPTH = 512                     // words in the macro
) (
  input  logic                     RW0_clk,
  input  logic                     en,          // chip select, active high
  input  logic                     wmode,       // 1 write, 0 read
  input  logic [MACRO_BYTES-1:0]   wmask,       // byte lane enables
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [MACRO_WIDTH-1:0]   wdata,
  output logic [MACRO_WIDTH-1:0]   dout         // registered read data
);

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  logic [MACRO_WIDTH-1:0] mem [DEPTH];           // contents undefined at start

  // ----------------------------------------------------------------------
  // single port access
  // ----------------------------------------------------------------------
  always_ff @(posedge RW0_clk) begin
    if (en) begin
      if (wmode) begin
        for (int b = 0; b < MACRO_BYTES; b++) begin
          if (wmask[b]) begin
            mem[addr][b*8 +: 8] <= wdata[b*8 +: 8]; // masked lane write
          end
        end
      end else begin
        dout <= mem[addr];                      // read, held until next read
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // address must stay inside the macro for any selected cycle
  a_addr_in_range: assert property (
    @(posedge RW0_clk) en |-> (addr < DEPTH)
  ) else $error("sram_macro: addr %0d outside depth %0d", addr, DEPTH);

endmodule

`default_nettype wire

//--- src/dcache_data_array.sv
`default_nettype none

// D-cache data array, 1024 x 64 bits with byte write enables.
// The top address bit picks one of two banks; each bank is a low and
// a high 32-bit macro sharing enable and address.
module dcache_data_array
  import dcache_ram_pkg::*;
(
  input  logic                  RW0_clk,
  input  logic                  rst,         // sync, active high
  input  dc_data_req_t          req,
  output logic [DATA_WIDTH-1:0] rdata        // valid the cycle after a read
);

  // ----------------------------------------------------------------------
  // bank decode
  // ----------------------------------------------------------------------
  logic [DATA_BANKS-1:0]        bank_en;     // one-hot or zero
  logic [DATA_BANKS-1:0]        rd_sel;      // bank enabled last cycle
  logic [DATA_ADDR_WIDTH-2:0]   bank_addr;   // word within a bank
  logic [DATA_WIDTH-1:0]        bank_dout [DATA_BANKS];

  assign bank_addr = req.addr[DATA_ADDR_WIDTH-2:0];  // msb dropped, used for decode

  always_comb begin
    for (int i = 0; i < DATA_BANKS; i++) begin
      bank_en[i] = req.en && (req.addr[DATA_ADDR_WIDTH-1] == i[0]);
    end
  end

  // ----------------------------------------------------------------------
  // macro pairs, half 0 is bits 31:0, half 1 is bits 63:32
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < DATA_BANKS; g++) begin : g_bank
    for (genvar h = 0; h < DATA_WIDTH / MACRO_WIDTH; h++) begin : g_half
      sram_macro #(
        .DEPTH   (DATA_BANK_DEPTH)
      ) i_sram_macro (
        .RW0_clk (RW0_clk),
        .en      (bank_en[g]),                                  // per-bank select
        .wmode   (req.wmode),
        .wmask   (req.wmask[h*MACRO_BYTES +: MACRO_BYTES]),     // lanes of this half
        .addr    (bank_addr),
        .wdata   (req.wdata[h*MACRO_WIDTH +: MACRO_WIDTH]),
        .dout    (bank_dout[g][h*MACRO_WIDTH +: MACRO_WIDTH])
      );
    end
  end

  // ----------------------------------------------------------------------
  // read select
  // ----------------------------------------------------------------------
  // remembers which bank was touched so the right pair drives rdata
  always_ff @(posedge RW0_clk) begin
    if (rst) begin
      rd_sel <= '0;
    end else begin
      rd_sel <= bank_en;                    // zero when idle
    end
  end

  // and-or mux, zero when nothing was selected
  always_comb begin
    rdata = '0;
    for (int i = 0; i < DATA_BANKS; i++) begin
      if (rd_sel[i]) begin
        rdata = rdata | bank_dout[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_bank_en_onehot: assert property (
    @(posedge RW0_clk) disable iff (rst) $onehot0(bank_en)
  ) else $error("dcache_data_array: more than one bank enabled");

  // select is idle or names exactly one bank
  a_sel_onehot: assert property (
    @(posedge RW0_clk) disable iff (rst) $onehot0(rd_sel)
  ) else $error("dcache_data_array: bad read select %b", rd_sel);

endmodule

`default_nettype wire

//--- src/dcache_tag_array.sv
`default_nettype none

// D-cache tag array, 64 sets of two 21-bit ways.
// Each way lives in its own 32-bit macro; the upper bits are padding
// and a way mask bit turns into all four byte lanes of that macro.
module dcache_tag_array
  import dcache_ram_pkg::*;
(
  input  logic                                      RW0_clk,
  input  dc_tag_req_t                               req,
  output logic [TAG_WAYS-1:0][TAG_WAY_WIDTH-1:0]    rdata   // way 1 upper
);

  // ----------------------------------------------------------------------
  // request shaping
  // ----------------------------------------------------------------------
  logic [$clog2(TAG_MACRO_DEPTH)-1:0] macro_addr;           // widened set index
  logic [MACRO_WIDTH-1:0]             way_din  [TAG_WAYS];  // padded tags
  logic [MACRO_BYTES-1:0]             way_mask [TAG_WAYS];  // lanes per way
  logic [MACRO_WIDTH-1:0]             way_dout [TAG_WAYS];

  // upper macro rows never used
  assign macro_addr = {{($clog2(TAG_MACRO_DEPTH) - TAG_ADDR_WIDTH){1'b0}}, req.addr};

  // ----------------------------------------------------------------------
  // one macro per way
  // ----------------------------------------------------------------------
  for (genvar w = 0; w < TAG_WAYS; w++) begin : g_way
    assign way_din[w]  = {{(MACRO_WIDTH - TAG_WAY_WIDTH){1'b0}}, req.wdata[w]}; // zero pad
    assign way_mask[w] = {MACRO_BYTES{req.wmask[w]}};      // whole word or nothing
    assign rdata[w]    = way_dout[w][TAG_WAY_WIDTH-1:0];   // drop padding

    sram_macro #(
      .DEPTH   (TAG_MACRO_DEPTH)
    ) i_sram_macro (
      .RW0_clk (RW0_clk),
      .en      (req.en),                // both ways accessed together
      .wmode   (req.wmode),
      .wmask   (way_mask[w]),
      .addr    (macro_addr),
      .wdata   (way_din[w]),
      .dout    (way_dout[w])
    );

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // padding is only ever written as zero, so it must read back as zero
    a_pad_zero: assert property (
      @(posedge RW0_clk) (req.en && !req.wmode)
        |=> (way_dout[w][MACRO_WIDTH-1:TAG_WAY_WIDTH] == '0)
    ) else $error("dcache_tag_array: way %0d padding nonzero", w);
  end

endmodule

`default_nettype wire

//--- src/dcache_arrays.sv
`default_nettype none

// D-cache storage top, data array and tag array side by side.
// Both arrays answer a read one cycle after it is issued and accept
// one request per cycle with no back-pressure.
module dcache_arrays
  import dcache_ram_pkg::*;
(
  input  logic                                    RW0_clk,
  input  logic                                    rst,         // clears data read select only

  // ----------------------------------------------------------------------
  // data array side
  // ----------------------------------------------------------------------
  input  dc_data_req_t                            data_req,
  output logic [DATA_WIDTH-1:0]                   data_rdata,  // cycle after read

  // ----------------------------------------------------------------------
  // tag array side
  // ----------------------------------------------------------------------
  input  dc_tag_req_t                             tag_req,
  output logic [TAG_WAYS-1:0][TAG_WAY_WIDTH-1:0]  tag_rdata    // cycle after read
);

  // ----------------------------------------------------------------------
  // data array
  // ----------------------------------------------------------------------
  // 2 banks x 2 macros, bank chosen by the address msb
  dcache_data_array i_dcache_data_array (
    .RW0_clk (RW0_clk),
    .rst     (rst),
    .req     (data_req),     // struct passed straight through
    .rdata   (data_rdata)
  );

  // ----------------------------------------------------------------------
  // tag array
  // ----------------------------------------------------------------------
  // one macro per way, both ways read together
  dcache_tag_array i_dcache_tag_array (
    .RW0_clk (RW0_clk),
    .req     (tag_req),      // struct passed straight through
    .rdata   (tag_rdata)
  );

endmodule

`default_nettype wire

//--- dv/tb_dcache_tasks.svh
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

// ------------------------------------------------------------------------
// request builders
// ------------------------------------------------------------------------
function automatic dc_data_req_t data_idle();
  dc_data_req_t r;
  r = '0;                                      // en low, nothing happens
  return r;
endfunction

function automatic dc_data_req_t data_read(input logic [DATA_ADDR_WIDTH-1:0] addr);
  dc_data_req_t r;
  r       = '0;
  r.en    = 1'b1;
  r.addr  = addr;
  return r;
endfunction

function automatic dc_data_req_t data_write(input logic [DATA_ADDR_WIDTH-1:0] addr,
                                            input logic [DATA_WIDTH-1:0]      wdata,
                                            input logic [DATA_BYTES-1:0]      wmask);
  dc_data_req_t r;
  r.en    = 1'b1;
  r.wmode = 1'b1;
  r.addr  = addr;
  r.wmask = wmask;
  r.wdata = wdata;
  return r;
endfunction

function automatic dc_tag_req_t tag_idle();
  dc_tag_req_t r;
  r = '0;
  return r;
endfunction

function automatic dc_tag_req_t tag_read(input logic [TAG_ADDR_WIDTH-1:0] addr);
  dc_tag_req_t r;
  r      = '0;
  r.en   = 1'b1;
  r.addr = addr;
  return r;
endfunction

function automatic dc_tag_req_t tag_write(input logic [TAG_ADDR_WIDTH-1:0] addr,
                                          input tag_way_t way1, input tag_way_t way0,
                                          input logic [TAG_WAYS-1:0] wmask);
  dc_tag_req_t r;
  r.en       = 1'b1;
  r.wmode    = 1'b1;
  r.addr     = addr;
  r.wmask    = wmask;
  r.wdata[1] = way1;                           // upper half
  r.wdata[0] = way0;
  return r;
endfunction

// ------------------------------------------------------------------------
// reference model helpers
// ------------------------------------------------------------------------
function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                      input logic [DATA_WIDTH-1:0] new_word,
                                                      input logic [DATA_BYTES-1:0] mask);
  logic [DATA_WIDTH-1:0] result;
  result = old_word;
  for (int b = 0; b < DATA_BYTES; b++) begin
    if (mask[b]) result[b*8 +: 8] = new_word[b*8 +: 8];  // set bit takes new byte
  end
  return result;
endfunction

function automatic tag_set_t merge_ways(input tag_set_t old_set, input tag_set_t new_set,
                                        input logic [TAG_WAYS-1:0] mask);
  tag_set_t result;
  result = old_set;
  for (int w = 0; w < TAG_WAYS; w++) begin
    if (mask[w]) result[w] = new_set[w];
  end
  return result;
endfunction

function automatic logic [DATA_WIDTH-1:0] random_word();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = $random(seed);
  lo = $random(seed);
  return {hi, lo};
endfunction

function automatic tag_way_t random_tag();
  logic [31:0] r;
  r = $random(seed);
  return r[TAG_WAY_WIDTH-1:0];                 // keep low tag bits
endfunction

// ------------------------------------------------------------------------
// one clock: check last cycle's reads, drive the new requests
// ------------------------------------------------------------------------
task automatic check_previous_reads();
  if (data_pend) begin
    checks++;
    if (data_rdata !== data_pend_exp) begin
      errors++;
      $display("[FAIL] %0t data_rdata expected %h got %h", $time, data_pend_exp, data_rdata);
    end
  end
  if (tag_pend) begin
    checks++;
    if (tag_rdata !== tag_pend_exp) begin
      errors++;
      $display("[FAIL] %0t tag_rdata expected %h got %h", $time, tag_pend_exp, tag_rdata);
    end
  end
endtask

task automatic issue_cycle(input dc_data_req_t d, input dc_tag_req_t t);
  logic                  d_exp_valid;
  logic [DATA_WIDTH-1:0] d_exp;
  logic                  t_exp_valid;
  tag_set_t              t_exp;
  d_exp_valid = d.en && !d.wmode;
  d_exp       = ref_data[d.addr];              // reads see all earlier writes
  t_exp_valid = t.en && !t.wmode;
  t_exp       = ref_tag[t.addr];
  if (d.en && d.wmode) ref_data[d.addr] = merge_bytes(ref_data[d.addr], d.wdata, d.wmask);
  if (t.en && t.wmode) ref_tag[t.addr] = merge_ways(ref_tag[t.addr], t.wdata, t.wmask);
  @(posedge RW0_clk);
  data_req <= d;                               // sampled on the next edge
  tag_req  <= t;
  @(negedge RW0_clk);
  check_previous_reads();                      // read from one edge back is valid now
  data_pend     = d_exp_valid;
  data_pend_exp = d_exp;
  tag_pend      = t_exp_valid;
  tag_pend_exp  = t_exp;
endtask

// ------------------------------------------------------------------------
// directed tests
// ------------------------------------------------------------------------
task automatic test_bank_separation();
  logic [DATA_ADDR_WIDTH-1:0] addr0;
  logic [DATA_ADDR_WIDTH-1:0] addr1;
  addr0 = 10'h015;                             // bank 0
  addr1 = addr0 | 10'h200;                     // same row, bank 1
  issue_cycle(data_write(addr0, 64'h0123_4567_89ab_cdef, '1), tag_idle());
  issue_cycle(data_write(addr1, 64'hfedc_ba98_7654_3210, '1), tag_idle());
  issue_cycle(data_read(addr0), tag_idle());
  issue_cycle(data_read(addr1), tag_idle());
  issue_cycle(data_idle(), tag_idle());
endtask

task automatic test_byte_masks();
  issue_cycle(data_write(10'h123, {8{8'h11}}, '1), tag_idle());
  issue_cycle(data_write(10'h2a7, 64'h0706_0504_0302_0100, '1), tag_idle());
  issue_cycle(data_write(10'h123, {8{8'haa}}, 8'ha5), tag_idle());  // scattered lanes
  issue_cycle(data_write(10'h2a7, 64'hdead_beef_cafe_f00d, 8'h0f), tag_idle());  // low half
  issue_cycle(data_read(10'h123), tag_idle());
  issue_cycle(data_read(10'h2a7), tag_idle());
  issue_cycle(data_idle(), tag_idle());
endtask

task automatic test_tag_ways();
  issue_cycle(data_idle(), tag_write(6'h2a, 21'h1abcd, 21'h0f0f0, 2'b11));
  issue_cycle(data_idle(), tag_write(6'h2a, 21'h15555, 21'h1ffff, 2'b10)); // way 1 only
  issue_cycle(data_idle(), tag_read(6'h2a));
  issue_cycle(data_idle(), tag_idle());
endtask

task automatic test_pipelined_reads();
  logic [DATA_ADDR_WIDTH-1:0] daddr [4];
  logic [TAG_ADDR_WIDTH-1:0]  tset  [4];
  daddr[0] = 10'h040;                          // bank 0
  daddr[1] = 10'h240;                          // bank 1
  daddr[2] = 10'h07f;                          // bank 0
  daddr[3] = 10'h3ff;                          // bank 1, last word
  tset[0]  = 6'h00;
  tset[1]  = 6'h3f;
  tset[2]  = 6'h11;
  tset[3]  = 6'h22;
  for (int i = 0; i < 4; i++) begin
    issue_cycle(data_write(daddr[i], random_word(), '1),
                tag_write(tset[i], random_tag(), random_tag(), '1));
  end
  for (int i = 0; i < 16; i++) begin
    issue_cycle(data_read(daddr[i % 4]), tag_read(tset[(i + 1) % 4]));  // back to back
  end
  issue_cycle(data_idle(), tag_idle());
endtask

task automatic test_random_mix();
  logic [DATA_ADDR_WIDTH-1:0] data_pool [RANDOM_DATA_POOL];
  logic [TAG_ADDR_WIDTH-1:0]  tag_pool  [RANDOM_TAG_POOL];
  dc_data_req_t               d;
  dc_tag_req_t                t;
  logic [31:0]                r;
  // fill the pools fully so every later read has a known value
  for (int i = 0; i < RANDOM_DATA_POOL; i++) begin
    r            = $random(seed);
    data_pool[i] = r[DATA_ADDR_WIDTH-1:0];
    t            = tag_idle();
    if (i < RANDOM_TAG_POOL) begin
      tag_pool[i] = r[DATA_ADDR_WIDTH +: TAG_ADDR_WIDTH];
      t           = tag_write(tag_pool[i], random_tag(), random_tag(), '1);
    end
    issue_cycle(data_write(data_pool[i], random_word(), '1), t);
  end
  for (int c = 0; c < RANDOM_CYCLES; c++) begin
    r = $random(seed);
    case (r[1:0])                              // data op
      2'd0:    d = data_idle();
      2'd3:    d = data_write(data_pool[r[7:4]], random_word(), r[15:8]);
      default: d = data_read(data_pool[r[7:4]]);
    endcase
    case (r[3:2])                              // tag op
      2'd0:    t = tag_idle();
      2'd3:    t = tag_write(tag_pool[r[18:16]], random_tag(), random_tag(), r[21:20]);
      default: t = tag_read(tag_pool[r[18:16]]);
    endcase
    issue_cycle(d, t);
  end
endtask

`endif

//--- dv/tb_dcache_arrays.sv
`default_nettype none

module tb_dcache_arrays
  import dcache_ram_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------------------------------------
  // run length, used by the watchdog
  // ----------------------------------------------------------------------
  localparam int CLK_PERIOD         = 20;         // ns
  localparam int RESET_CYCLES       = 3;
  localparam int BANK_TEST_CYCLES   = 5;          // 2 writes, 2 reads, drain
  localparam int MASK_TEST_CYCLES   = 7;          // 4 writes, 2 reads, drain
  localparam int TAG_TEST_CYCLES    = 4;          // 2 writes, 1 read, drain
  localparam int PIPE_TEST_CYCLES   = 21;         // 4 fills, 16 reads, drain
  localparam int RANDOM_DATA_POOL   = 16;         // addresses touched by random mix
  localparam int RANDOM_TAG_POOL    = 8;          // sets touched by random mix
  localparam int RANDOM_CYCLES      = 200;
  localparam int RANDOM_TEST_CYCLES = RANDOM_DATA_POOL + RANDOM_CYCLES;
  localparam int TOTAL_CYCLES       = RESET_CYCLES + BANK_TEST_CYCLES + MASK_TEST_CYCLES
                                    + TAG_TEST_CYCLES + PIPE_TEST_CYCLES
                                    + RANDOM_TEST_CYCLES + 1;  // final drain
  localparam int MARGIN_CYCLES      = 100;

  typedef tag_way_t [TAG_WAYS-1:0] tag_set_t;    // both ways of one set

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------
  logic                                   RW0_clk;
  logic                                   rst;
  dc_data_req_t                           data_req;
  logic [DATA_WIDTH-1:0]                  data_rdata;
  dc_tag_req_t                            tag_req;
  logic [TAG_WAYS-1:0][TAG_WAY_WIDTH-1:0] tag_rdata;

  // ----------------------------------------------------------------------
  // reference model and scoreboard state
  // ----------------------------------------------------------------------
  logic [DATA_WIDTH-1:0] ref_data [DATA_BANKS*DATA_BANK_DEPTH];  // expected storage
  tag_set_t              ref_tag  [TAG_DEPTH];

  logic                  data_pend;      // data read issued last cycle
  logic [DATA_WIDTH-1:0] data_pend_exp;
  logic                  tag_pend;       // tag read issued last cycle
  tag_set_t              tag_pend_exp;

  integer seed;                          // $random state
  int     errors;
  int     checks;

  dcache_arrays i_dcache_arrays (
    .RW0_clk    (RW0_clk),
    .rst        (rst),
    .data_req   (data_req),
    .data_rdata (data_rdata),
    .tag_req    (tag_req),
    .tag_rdata  (tag_rdata)
  );

  `include "tb_dcache_tasks.svh"

  // clock
  initial begin
    RW0_clk = 1'b0;
    forever #(CLK_PERIOD / 2) RW0_clk = ~RW0_clk;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    seed          = 78;
    errors        = 0;
    checks        = 0;
    data_pend     = 1'b0;
    data_pend_exp = '0;
    tag_pend      = 1'b0;
    tag_pend_exp  = '0;
    rst           = 1'b1;                    // held for the first cycles
    data_req      = '0;
    tag_req       = '0;

    repeat (RESET_CYCLES) @(posedge RW0_clk);
    rst <= 1'b0;

    test_bank_separation();
    test_byte_masks();
    test_tag_ways();
    test_pipelined_reads();
    test_random_mix();
    issue_cycle(data_idle(), tag_idle());    // checks the last read

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests did not complete within %0d cycles",
             TOTAL_CYCLES + MARGIN_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+dv
src/dcache_ram_pkg.sv
src/sram_macro.sv
src/dcache_data_array.sv
src/dcache_tag_array.sv
src/dcache_arrays.sv
dv/tb_dcache_arrays.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the D-cache arrays testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_dcache_arrays -o tb_dcache_arrays \
  > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "build failed, see $BUILD_LOG"; exit 1; }

# a crash or assertion stop also counts as a failed run
./obj_dir/tb_dcache_arrays > "$SIM_LOG" 2>&1 \
  || echo "Testbench failed" >> "$SIM_LOG"

cat "$SIM_LOG"

grep -q "Testbench failed" "$SIM_LOG" \
  && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }
